// File: source/coherence_pkg.sv
// Shared types for the two-core MESI coherence controller.
// Holds the data and address words, the request opcodes, the controller
// and L2 state encodings, and the structs passed between the arbiter,
// the controller and the L2 bank. Modules import it inside their bodies.
package coherence_pkg;

    localparam int NUM_CORES = 2;             // dual core only.

    typedef logic [31:0] word_t;              // one data word.
    typedef logic [31:0] addr_t;              // byte address of a word.

    typedef enum logic [1:0] {
        CC_READ  = 2'b00,                     // read miss.
        CC_WRITE = 2'b01,                     // write miss, other copy invalidated.
        CC_WB    = 2'b10,                     // write-back of a dirty block.
        CC_INV   = 2'b11                      // upgrade, invalidate only.
    } cc_op_t;

    typedef enum logic [4:0] {
        IDLE, SNP1, SNP2,
        LOAD1, LOAD2,
        FWDWB1, FWDWB2, FWDWB3,
        FWDEX1, FWDEX2, FWDEX3,
        LOADEX1, LOADEX2, LOADEX3,
        WB1, WB2,
        INV
    } cc_state_t;

    typedef enum logic [1:0] {
        L2_FREE,                              // no request pending.
        L2_BUSY,                              // counting latency.
        L2_ACCESS                             // word moves this cycle.
    } l2_state_t;

    typedef struct packed {
        logic   valid;                        // a core holds the grant.
        logic   core;                         // granted core index.
        cc_op_t op;                           // decoded request.
    } cc_grant_t;

    typedef struct packed {
        logic  ren;                           // read one word.
        logic  wen;                           // write one word.
        addr_t addr;
        word_t store;
    } l2_req_t;

endpackage

// File: source/core_arbiter.sv
// Round-robin arbiter between the two cores' transfer requests.
// Registers a grant one cycle after a request while idle, decodes the
// chosen core's request bits into an opcode and holds the grant until
// the controller pulses done. Core 0 wins the first tie after reset.
module core_arbiter (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic [coherence_pkg::NUM_CORES-1:0]  cctrans,
    input  logic [coherence_pkg::NUM_CORES-1:0]  dREN,
    input  logic [coherence_pkg::NUM_CORES-1:0]  dWEN,
    input  logic [coherence_pkg::NUM_CORES-1:0]  ccwrite,
    input  logic                                 done,
    output coherence_pkg::cc_grant_t             grant
);
    import coherence_pkg::*;

    logic      ptr;                           // core preferred on a tie.
    logic      pick;                          // core chosen this cycle.
    cc_grant_t grant_next;

    // request bits of one core to opcode.
    function automatic cc_op_t decode_op(input logic c);
        if (dWEN[c])
            return CC_WB;
        else if (dREN[c] && ccwrite[c])
            return CC_WRITE;
        else if (dREN[c])
            return CC_READ;
        return CC_INV;                        // transfer with no data.
    endfunction

    always_comb begin
        pick       = cctrans[ptr] ? ptr : ~ptr;
        grant_next = grant;
        if (done) begin
            grant_next.valid = 1'b0;          // release, one idle cycle.
        end else if (!grant.valid && |cctrans) begin
            grant_next.valid = 1'b1;
            grant_next.core  = pick;
            grant_next.op    = decode_op(pick);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ptr   <= 1'b0;
            grant <= '0;
        end else begin
            grant <= grant_next;
            if (!grant.valid && grant_next.valid)
                ptr <= ~pick;                 // other core first next time.
        end
    end

endmodule

// File: source/coherence_ctrl.sv
// MESI coherence state machine for two cores sharing one L2.
// Serves the granted request one block at a time, one word per step:
// snoops the other core, loads from L2 or forwards a dirty copy,
// writes blocks back and invalidates the other copy on writes.
// Pulses done in the last cycle of each transaction.
module coherence_ctrl #(
    parameter int BLOCK_SIZE = 2              // words per block.
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  coherence_pkg::cc_grant_t             grant,
    output logic                                 done,
    input  logic [coherence_pkg::NUM_CORES-1:0]  cctrans,
    input  logic [coherence_pkg::NUM_CORES-1:0]  ccwrite,
    input  logic [coherence_pkg::NUM_CORES-1:0]  cchit,
    input  logic [coherence_pkg::NUM_CORES-1:0]  ccdirty,
    input  coherence_pkg::addr_t                 daddr [coherence_pkg::NUM_CORES],
    input  coherence_pkg::word_t                 dstore [coherence_pkg::NUM_CORES],
    output logic [coherence_pkg::NUM_CORES-1:0]  dwait,
    output coherence_pkg::word_t                 dload [coherence_pkg::NUM_CORES],
    output logic [coherence_pkg::NUM_CORES-1:0]  ccwait,
    output logic [coherence_pkg::NUM_CORES-1:0]  ccinv,
    output logic [coherence_pkg::NUM_CORES-1:0]  ccexclusive,
    output coherence_pkg::addr_t                 ccsnpaddr [coherence_pkg::NUM_CORES],
    output coherence_pkg::l2_req_t               l2_req,
    input  coherence_pkg::l2_state_t             l2state,
    input  coherence_pkg::word_t                 l2load
);
    import coherence_pkg::*;

    localparam int CNT_W = $clog2(BLOCK_SIZE) + 1;

    cc_state_t        s, ns;
    logic [CNT_W-1:0] word_cnt, cnt_next;
    logic             req, oth;               // requester and snooped core.
    logic             last_word;
    logic             l2_done;
    logic             snp_hit;                // other core hit in snoop.

    assign req       = grant.core;
    assign oth       = ~grant.core;
    assign last_word = (word_cnt == CNT_W'(BLOCK_SIZE - 1));
    assign l2_done   = (l2state == L2_ACCESS);
    assign done      = (s != IDLE) && (ns == IDLE);

    // each core sees the other core's address while snooped.
    always_comb begin
        for (int i = 0; i < NUM_CORES; i++)
            ccsnpaddr[i] = daddr[NUM_CORES-1-i];
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            s        <= IDLE;
            word_cnt <= '0;
            snp_hit  <= 1'b0;
        end else begin
            s        <= ns;
            word_cnt <= cnt_next;
            if (s == SNP2)
                snp_hit <= cchit[oth];        // kept for the E/S choice.
        end
    end

    always_comb begin
        ns          = s;
        cnt_next    = word_cnt;
        dwait       = '1;
        ccwait      = '0;
        ccinv       = '0;
        ccexclusive = '0;
        l2_req      = '0;
        for (int i = 0; i < NUM_CORES; i++)
            dload[i] = '0;
        case (s)
            IDLE: begin
                cnt_next = '0;
                if (grant.valid) begin
                    case (grant.op)
                        CC_WB:   ns = WB1;
                        CC_INV:  ns = INV;
                        default: ns = SNP1;   // read or write miss.
                    endcase
                end
            end
            SNP1: begin
                ccwait[oth] = 1'b1;           // give the snooped core a cycle.
                ns = SNP2;
            end
            SNP2: begin
                ccwait[oth] = 1'b1;
                if (!cctrans[req])
                    ns = IDLE;                // request withdrawn.
                else if (ccwrite[req] || grant.op == CC_WRITE)
                    ns = (cchit[oth] && ccdirty[oth]) ? FWDEX1 : LOADEX1;
                else
                    ns = (cchit[oth] && ccdirty[oth]) ? FWDWB1 : LOAD1;
            end
            // read, filled from L2, E if no sharer.
            LOAD1: begin
                l2_req.ren        = 1'b1;
                l2_req.addr       = daddr[req];
                dload[req]        = l2load;
                dwait[req]        = ~l2_done;
                ccexclusive[req]  = ~snp_hit;
                if (l2_done)
                    ns = LOAD2;
            end
            LOAD2: begin
                ccexclusive[req] = ~snp_hit;
                ns       = last_word ? IDLE : LOAD1;
                cnt_next = last_word ? '0 : word_cnt + 1'b1;
            end
            // read of a dirty copy, forwarded and written to L2.
            FWDWB1: begin
                ccwait[oth] = 1'b1;
                dload[req]  = dstore[oth];
                dwait[req]  = 1'b0;
                ns = FWDWB2;
            end
            FWDWB2: begin
                ccwait[oth]  = 1'b1;
                l2_req.wen   = 1'b1;
                l2_req.addr  = daddr[oth];
                l2_req.store = dstore[oth];
                dwait[oth]   = ~l2_done;      // snooped core steps its word.
                if (l2_done)
                    ns = FWDWB3;
            end
            FWDWB3: begin
                ccwait[oth] = 1'b1;
                ns       = last_word ? IDLE : FWDWB1;
                cnt_next = last_word ? '0 : word_cnt + 1'b1;
            end
            // write miss with a dirty sharer, L2 left stale.
            FWDEX1: begin
                ccwait[oth] = 1'b1;
                dload[req]  = dstore[oth];
                dwait[req]  = 1'b0;
                ns = FWDEX2;
            end
            FWDEX2: begin
                ccwait[oth] = 1'b1;
                ns       = last_word ? FWDEX3 : FWDEX1;
                cnt_next = last_word ? '0 : word_cnt + 1'b1;
            end
            FWDEX3: begin
                ccwait[oth] = 1'b1;
                ccinv[oth]  = 1'b1;
                ns = IDLE;
            end
            // write miss, filled from L2 into M.
            LOADEX1: begin
                ccwait[oth]      = 1'b1;
                l2_req.ren       = 1'b1;
                l2_req.addr      = daddr[req];
                dload[req]       = l2load;
                dwait[req]       = ~l2_done;
                ccexclusive[req] = 1'b1;
                if (l2_done)
                    ns = LOADEX2;
            end
            LOADEX2: begin
                ccwait[oth]      = 1'b1;
                ccexclusive[req] = 1'b1;
                ns       = last_word ? LOADEX3 : LOADEX1;
                cnt_next = last_word ? '0 : word_cnt + 1'b1;
            end
            LOADEX3: begin
                ccwait[oth] = 1'b1;
                ccinv[oth]  = 1'b1;
                ns = IDLE;
            end
            // write-back, one word per L2 access.
            WB1: begin
                l2_req.wen   = 1'b1;
                l2_req.addr  = daddr[req];
                l2_req.store = dstore[req];
                dwait[req]   = ~l2_done;
                if (l2_done)
                    ns = WB2;
            end
            WB2: begin
                ns       = last_word ? IDLE : WB1;
                cnt_next = last_word ? '0 : word_cnt + 1'b1;
            end
            INV: begin
                ccwait[oth] = 1'b1;
                ccinv[oth]  = 1'b1;           // upgrade, no data moves.
                ns = IDLE;
            end
            default: ns = IDLE;
        endcase
    end

endmodule

// File: source/l2_bank.sv
// Small word array standing in for the shared L2.
// Each read or write request waits L2_LATENCY busy cycles, then one
// word moves in the L2_ACCESS cycle. The requester must hold the
// request until then and drop it to let the bank return to free.
module l2_bank #(
    parameter int BLOCK_SIZE = 2,             // words per block.
    parameter int L2_LATENCY = 2,             // busy cycles per access.
    parameter int L2_WORDS   = 64             // array size in words.
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  coherence_pkg::l2_req_t    l2_req,
    output coherence_pkg::l2_state_t  l2state,
    output coherence_pkg::word_t      l2load
);
    import coherence_pkg::*;

    localparam int NUM_BLOCKS = L2_WORDS / BLOCK_SIZE;
    localparam int IDX_W      = $clog2(L2_WORDS);
    localparam int LAT_W      = $clog2(L2_LATENCY + 1) + 1;

    word_t            mem [L2_WORDS];
    l2_state_t        next_state;
    logic [LAT_W-1:0] lat_cnt;
    logic [IDX_W-1:0] idx;
    logic [31:0]      word_addr;
    logic             active;

    assign active    = l2_req.ren || l2_req.wen;
    assign word_addr = l2_req.addr >> 2;      // byte to word address.
    // wrap by whole blocks so a block never straddles the array end.
    assign idx = IDX_W'(((word_addr / BLOCK_SIZE) % NUM_BLOCKS) * BLOCK_SIZE
                        + (word_addr % BLOCK_SIZE));
    assign l2load = mem[idx];

    always_comb begin
        next_state = l2state;
        case (l2state)
            L2_FREE:   if (active) next_state = L2_BUSY;
            L2_BUSY: begin
                if (!active)
                    next_state = L2_FREE;     // request dropped early.
                else if (int'(lat_cnt) + 1 >= L2_LATENCY)
                    next_state = L2_ACCESS;
            end
            L2_ACCESS: next_state = active ? L2_BUSY : L2_FREE;
            default:   next_state = L2_FREE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            l2state <= L2_FREE;
            lat_cnt <= '0;
            for (int i = 0; i < L2_WORDS; i++)
                mem[i] <= '0;                 // bank starts cleared.
        end else begin
            l2state <= next_state;
            lat_cnt <= (l2state == L2_BUSY) ? lat_cnt + 1'b1 : '0;
            if (l2state == L2_ACCESS && l2_req.wen)
                mem[idx] <= l2_req.store;
        end
    end

endmodule

// File: source/coherence_top.sv
// Top level of the two-core coherence subsystem.
// Connects the core arbiter, the MESI controller and the L2 bank and
// exposes one cache-side port group per core, indexed 0 and 1.
module coherence_top #(
    parameter int BLOCK_SIZE = 2,
    parameter int L2_LATENCY = 2
) (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic [coherence_pkg::NUM_CORES-1:0]  cctrans,
    input  logic [coherence_pkg::NUM_CORES-1:0]  dREN,
    input  logic [coherence_pkg::NUM_CORES-1:0]  dWEN,
    input  logic [coherence_pkg::NUM_CORES-1:0]  ccwrite,
    input  coherence_pkg::addr_t                 daddr [coherence_pkg::NUM_CORES],
    input  coherence_pkg::word_t                 dstore [coherence_pkg::NUM_CORES],
    input  logic [coherence_pkg::NUM_CORES-1:0]  cchit,
    input  logic [coherence_pkg::NUM_CORES-1:0]  ccdirty,
    output logic [coherence_pkg::NUM_CORES-1:0]  dwait,
    output coherence_pkg::word_t                 dload [coherence_pkg::NUM_CORES],
    output logic [coherence_pkg::NUM_CORES-1:0]  ccwait,
    output logic [coherence_pkg::NUM_CORES-1:0]  ccinv,
    output logic [coherence_pkg::NUM_CORES-1:0]  ccexclusive,
    output coherence_pkg::addr_t                 ccsnpaddr [coherence_pkg::NUM_CORES]
);
    import coherence_pkg::*;

    cc_grant_t grant;                         // arbiter to controller.
    logic      done;                          // controller back to arbiter.
    l2_req_t   l2_req;
    l2_state_t l2state;
    word_t     l2load;

    core_arbiter u_arbiter (
        .CLK, .nRST, .cctrans, .dREN, .dWEN, .ccwrite, .done, .grant
    );

    coherence_ctrl #(.BLOCK_SIZE(BLOCK_SIZE)) u_ctrl (
        .CLK, .nRST, .grant, .done,
        .cctrans, .ccwrite, .cchit, .ccdirty, .daddr, .dstore,
        .dwait, .dload, .ccwait, .ccinv, .ccexclusive, .ccsnpaddr,
        .l2_req, .l2state, .l2load
    );

    l2_bank #(
        .BLOCK_SIZE(BLOCK_SIZE),
        .L2_LATENCY(L2_LATENCY)
    ) u_l2 (
        .CLK, .nRST, .l2_req, .l2state, .l2load
    );

endmodule

// File: verification/coherence_asserts.sv
// Concurrent checks on the coherence controller's handshakes.
// Bound into coherence_ctrl by the testbench, it watches the grant, the
// snoop answers and the cache-side outputs and flags illegal pulses or overlaps.
module coherence_asserts (
    input logic                                 CLK,
    input logic                                 nRST,
    input coherence_pkg::cc_grant_t             grant,
    input logic [coherence_pkg::NUM_CORES-1:0]  cchit,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccdirty,
    input logic [coherence_pkg::NUM_CORES-1:0]  dwait,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccinv,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccexclusive
);
    timeunit 1ns;
    timeprecision 1ns;
    import coherence_pkg::*;

    int fails = 0;                            // read by the testbench top.

    inv0_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        ccinv[0] |=> !ccinv[0])
        else begin fails++; $error("ccinv[0] held for more than one cycle"); end

    inv1_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
        ccinv[1] |=> !ccinv[1])
        else begin fails++; $error("ccinv[1] held for more than one cycle"); end

    // only one core moves a word per cycle.
    single_ack: assert property (@(posedge CLK) disable iff (!nRST)
        dwait != 2'b00)
        else begin fails++; $error("both cores saw dwait low together"); end

    // a read that finds the other copy dirty is forwarded, never exclusive.
    fwd_not_excl: assert property (@(posedge CLK) disable iff (!nRST)
        (grant.valid && grant.op == CC_READ && cchit[!grant.core] && ccdirty[!grant.core])
            |-> (ccexclusive == '0))
        else begin fails++; $error("ccexclusive raised on a forwarded read"); end

endmodule

// File: verification/coherence_checker.sv
// Scoreboard for the coherence subsystem.
// Keeps a model of the L2 words, checks every loaded word taken while
// dwait is low, the exclusive and hold flags on each load, the snoop
// address and the invalidate pulse of each transaction against the
// expected flags from the testbench.
module coherence_checker (
    input logic                                 CLK,
    input logic                                 nRST,
    input logic [coherence_pkg::NUM_CORES-1:0]  cctrans,
    input logic [coherence_pkg::NUM_CORES-1:0]  dREN,
    input logic [coherence_pkg::NUM_CORES-1:0]  dWEN,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccwrite,
    input logic [coherence_pkg::NUM_CORES-1:0]  cchit,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccdirty,
    input logic [coherence_pkg::NUM_CORES-1:0]  dwait,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccwait,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccexclusive,
    input logic [coherence_pkg::NUM_CORES-1:0]  ccinv,
    input logic [coherence_pkg::NUM_CORES-1:0]  active,
    input logic [coherence_pkg::NUM_CORES-1:0]  exp_excl,
    input logic [coherence_pkg::NUM_CORES-1:0]  exp_inv,
    input coherence_pkg::addr_t                 daddr [coherence_pkg::NUM_CORES],
    input coherence_pkg::word_t                 dstore [coherence_pkg::NUM_CORES],
    input coherence_pkg::word_t                 dload [coherence_pkg::NUM_CORES],
    input coherence_pkg::addr_t                 ccsnpaddr [coherence_pkg::NUM_CORES]
);
    timeunit 1ns;
    timeprecision 1ns;
    import coherence_pkg::*;

    int         errors = 0;
    word_t      l2_model [addr_t];            // words written so far, rest zero.
    logic [1:0] saw_inv;                      // other core invalidated, per requester.
    logic [1:0] active_q;

    function automatic word_t model_word(input addr_t a);
        if (l2_model.exists(a))
            return l2_model[a];
        return '0;                            // bank clears on reset.
    endfunction

    task automatic mismatch(input string name, input word_t expv, input word_t actv);
        $display("ERROR %s expected %h got %h", name, expv, actv);
        errors++;
    endtask

    always @(posedge CLK) begin
        word_t expv;
        logic  held;                          // other core held for this word.
        if (!nRST) begin
            saw_inv  = '0;
            active_q = '0;
        end else begin
            for (int i = 0; i < NUM_CORES; i++) begin
                if (ccsnpaddr[i] !== daddr[1-i])
                    mismatch($sformatf("ccsnpaddr[%0d]", i), daddr[1-i], ccsnpaddr[i]);
                if (active[i] && ccinv[1-i])
                    saw_inv[i] = 1'b1;
                if (!dwait[i]) begin
                    if (active[i] && dWEN[i]) begin
                        l2_model[daddr[i]] = dstore[i];      // write-back word.
                    end else if (active[i] && dREN[i]) begin
                        held = (cchit[1-i] && ccdirty[1-i]) || ccwrite[i];
                        expv = (cchit[1-i] && ccdirty[1-i]) ? dstore[1-i]
                                                            : model_word(daddr[i]);
                        if (dload[i] !== expv)
                            mismatch($sformatf("dload[%0d]", i), expv, dload[i]);
                        if (ccexclusive[i] !== exp_excl[i])
                            mismatch($sformatf("ccexclusive[%0d]", i),
                                     exp_excl[i], ccexclusive[i]);
                        if (held && ccwait[1-i] !== 1'b1)
                            mismatch($sformatf("ccwait[%0d]", 1 - i), 1'b1, ccwait[1-i]);
                    end else if (!cctrans[i]) begin
                        l2_model[daddr[i]] = dstore[i];      // dirty copy to L2.
                        if (ccwait[i] !== 1'b1)
                            mismatch($sformatf("ccwait[%0d]", i), 1'b1, ccwait[i]);
                    end
                end
                if (active_q[i] && !active[i]) begin
                    if (saw_inv[i] !== exp_inv[i])
                        mismatch($sformatf("ccinv[%0d]", 1 - i), exp_inv[i], saw_inv[i]);
                    saw_inv[i] = 1'b0;
                end
            end
            active_q = active;
        end
    end

endmodule

// File: verification/tb_coherence.sv
// Testbench for the two-core coherence subsystem.
// Plays both L1 caches from the stimulus file: raises requests, steps
// words on dwait, answers snoops and supplies dirty words. Paired lines
// start on the same edge to exercise round-robin arbitration.
module tb_coherence;
    timeunit 1ns;
    timeprecision 1ns;
    import coherence_pkg::*;

    localparam int TIMEOUT = 400;             // cycles per transaction.

    typedef struct packed {
        logic        par;                     // runs together with the next line.
        logic        core;
        logic [1:0]  op;                      // 0 read, 1 write, 2 wb, 3 inv.
        logic [31:0] addr;
        logic [31:0] w0;
        logic [31:0] w1;
        logic        hit;                     // other core's snoop answer.
        logic        dirty;
        logic        excl;                    // expected ccexclusive.
        logic        inv;                     // expected ccinv to other core.
    } xact_t;

    logic       CLK;
    logic       nRST;
    logic [1:0] cctrans, dREN, dWEN, ccwrite, cchit, ccdirty;
    addr_t      daddr [NUM_CORES];
    word_t      dstore [NUM_CORES];
    logic [1:0] dwait, ccwait, ccinv, ccexclusive;
    word_t      dload [NUM_CORES];
    addr_t      ccsnpaddr [NUM_CORES];
    logic [1:0] active, exp_excl, exp_inv;
    int         tb_errors;
    int         seed;
    int         first_core;                   // core whose dwait fell first.
    logic       rr_ptr;                       // expected arbiter preference.
    logic       aborted;

    always #50 CLK = ~CLK;

    coherence_top #(.BLOCK_SIZE(2), .L2_LATENCY(2)) dut (
        .CLK, .nRST, .cctrans, .dREN, .dWEN, .ccwrite, .daddr, .dstore,
        .cchit, .ccdirty, .dwait, .dload, .ccwait, .ccinv, .ccexclusive, .ccsnpaddr
    );

    coherence_checker chk (
        .CLK, .nRST, .cctrans, .dREN, .dWEN, .ccwrite, .cchit, .ccdirty, .dwait,
        .ccwait, .ccexclusive, .ccinv, .active, .exp_excl, .exp_inv, .daddr, .dstore,
        .dload, .ccsnpaddr
    );

    bind coherence_ctrl coherence_asserts u_asserts (
        .CLK(CLK), .nRST(nRST), .grant(grant), .cchit(cchit), .ccdirty(ccdirty),
        .dwait(dwait), .ccinv(ccinv), .ccexclusive(ccexclusive)
    );

    // next data line, comment lines start with #.
    task automatic read_xact(input int fd, output xact_t x, output bit ok);
        string       line;
        int          n, par, core, op, hit, dirty, ex, inv;
        logic [31:0] a, w0, w1;
        ok = 0;
        x  = '0;
        while (!ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %h %h %h %d %d %d %d",
                            par, core, op, a, w0, w1, hit, dirty, ex, inv);
                if (n == 10) begin
                    x  = '{par[0], core[0], op[1:0], a, w0, w1,
                           hit[0], dirty[0], ex[0], inv[0]};
                    ok = 1;
                end
            end
        end
    endtask

    task automatic run_xact(input xact_t x);
        int    c, o, k, j, cyc;
        logic  fwd, step_r, step_s, fin;
        word_t w [2];
        c    = x.core;
        o    = 1 - c;
        w[0] = x.w0;
        w[1] = x.w1;
        k    = 0;
        j    = 0;
        cyc  = 0;
        fin  = 0;
        fwd  = x.hit && x.dirty && (x.op <= 1);   // other core supplies words.
        @(negedge CLK);
        cctrans[c] = 1'b1;
        dREN[c]    = (x.op <= 1);
        dWEN[c]    = (x.op == 2);
        ccwrite[c] = (x.op == 1);
        daddr[c]   = x.addr;
        dstore[c]  = w[0];
        cchit[o]   = x.hit;
        ccdirty[o] = x.dirty;
        if (fwd) begin
            daddr[o]  = x.addr;
            dstore[o] = w[0];
        end
        exp_excl[c] = x.excl;
        exp_inv[c]  = x.inv;
        active[c]   = 1'b1;
        while (!fin && !aborted) begin
            @(posedge CLK);
            step_r = !dwait[c];
            step_s = fwd && ((x.op == 1) ? !dwait[c] : !dwait[o]);  // write vs read fwd.
            if (!dwait[c] && first_core < 0)
                first_core = c;
            fin = dut.done && (dut.grant.core == c);
            @(negedge CLK);
            if (step_r) begin
                k++;
                daddr[c] = x.addr + 4 * k;
                if (k < 2)
                    dstore[c] = w[k];
            end
            if (step_s) begin
                j++;
                daddr[o] = x.addr + 4 * j;
                if (j < 2)
                    dstore[o] = w[j];
            end
            cyc++;
            if (!fin && cyc > TIMEOUT) begin
                $display("timeout: core %0d request at address %h never completed",
                         c, x.addr);
                tb_errors++;
                aborted = 1'b1;
            end
        end
        cctrans[c] = 1'b0;                    // dropped before the arbiter regrants.
        dREN[c]    = 1'b0;
        dWEN[c]    = 1'b0;
        ccwrite[c] = 1'b0;
        cchit[o]   = 1'b0;
        ccdirty[o] = 1'b0;
        active[c]  = 1'b0;
    endtask

    initial begin
        int    fd, total;
        bit    ok, ok2;
        xact_t x, y;
        CLK        = 1'b0;
        nRST       = 1'b0;
        cctrans    = '0;
        dREN       = '0;
        dWEN       = '0;
        ccwrite    = '0;
        cchit      = '0;
        ccdirty    = '0;
        daddr      = '{default: '0};
        dstore     = '{default: '0};
        active     = '0;
        exp_excl   = '0;
        exp_inv    = '0;
        tb_errors  = 0;
        seed       = 16;
        first_core = -1;
        rr_ptr     = 1'b0;                    // core 0 wins the first tie.
        aborted    = 1'b0;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        fd = $fopen("verification/coherence_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            tb_errors++;
        end else begin
            while (!aborted) begin
                read_xact(fd, x, ok);
                if (!ok)
                    break;
                if (x.par) begin
                    read_xact(fd, y, ok2);
                    if (!ok2) begin
                        $display("stimulus file ends inside a request pair");
                        tb_errors++;
                        break;
                    end
                    first_core = -1;
                    fork
                        run_xact(x);
                        run_xact(y);
                    join
                    if (!aborted && first_core != int'(rr_ptr)) begin
                        $display("ERROR first_core expected %h got %h", rr_ptr, first_core);
                        tb_errors++;
                    end
                end else begin
                    run_xact(x);
                    rr_ptr = ~x.core;
                    repeat ($unsigned($random(seed)) % 4) @(negedge CLK);
                end
            end
            $fclose(fd);
        end
        total = chk.errors + dut.u_ctrl.u_asserts.fails + tb_errors;
        $display("errors: checker %0d, assertions %0d, testbench %0d",
                 chk.errors, dut.u_ctrl.u_asserts.fails, tb_errors);
        if (total == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: verification/coherence_stimulus.txt
# par core op(0 rd 1 wr 2 wb 3 inv) addr word0 word1 hit dirty exp_excl exp_inv
# words are the write-back data, or the other core's dirty data when forwarded
0 0 2 00000010 AAAA0001 AAAA0002 0 0 0 0
0 1 0 00000010 00000000 00000000 0 0 1 0
0 0 0 00000010 00000000 00000000 1 0 0 0
0 1 0 00000020 BBBB0001 BBBB0002 1 1 0 0
0 0 0 00000020 00000000 00000000 0 0 1 0
0 0 1 00000030 CCCC0001 CCCC0002 1 1 0 1
0 1 1 00000010 00000000 00000000 0 0 1 1
0 0 3 00000040 00000000 00000000 0 0 0 1
1 0 0 00000018 00000000 00000000 0 0 1 0
0 1 0 00000028 00000000 00000000 0 0 1 0
0 1 0 00000030 00000000 00000000 0 0 1 0
1 0 0 00000020 00000000 00000000 0 0 1 0
0 1 0 00000010 00000000 00000000 0 0 1 0

// File: list.f
source/coherence_pkg.sv
source/core_arbiter.sv
source/coherence_ctrl.sv
source/l2_bank.sv
source/coherence_top.sv
verification/coherence_asserts.sv
verification/coherence_checker.sv
verification/tb_coherence.sv
